// File: common/cpu_defs.svh
// Core width and register macros
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// Data path and program counter width
`define CPU_DATA_W 16

// Register file depth
`define CPU_NUM_REGS 16

// Register index width
`define CPU_REG_W 4

// Written by CALL, read by RET
`define CPU_LINK_REG 15

`endif

// File: common/cpu_pkg.sv
// Processor types package
`default_nettype none

package cpu_pkg;

	typedef enum logic [3:0] {
		OP_ADD  = 4'd0,
		OP_SUB  = 4'd1,
		OP_AND  = 4'd2,
		OP_NOR  = 4'd3,
		OP_SLL  = 4'd4,
		OP_SRL  = 4'd5,
		OP_SRA  = 4'd6,
		OP_LHB  = 4'd7,
		OP_LLB  = 4'd8,
		OP_B    = 4'd9,
		OP_CALL = 4'd10,
		OP_RET  = 4'd11 // 12 to 15 decode as no-ops
	} opcode_e;

	typedef enum logic [2:0] {
		BR_NEQ, BR_EQ, BR_GT, BR_LT, BR_GTE, BR_LTE, BR_OVFL, BR_UNCOND
	} branch_cond_e;

	typedef enum logic [2:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_NOR, ALU_SLL, ALU_SRL, ALU_SRA
	} alu_op_e; // Matches opcode[2:0] for ALU ops

	typedef struct packed {
		opcode_e     opcode;
		logic [3:0]  rd;
		logic [3:0]  rs;
		logic [3:0]  rt;
	} reg_fmt_t;

	typedef struct packed {
		opcode_e     opcode;
		logic [3:0]  rd;
		logic [3:0]  rs;
		logic [3:0]  shamt;
	} shift_fmt_t;

	typedef struct packed {
		opcode_e     opcode;
		logic [3:0]  rd;
		logic [7:0]  imm;
	} half_fmt_t;

	typedef struct packed {
		opcode_e            opcode;
		branch_cond_e       cond;
		logic signed [8:0]  offset; // Relative to pc+1
	} branch_fmt_t;

	typedef struct packed {
		opcode_e      opcode;
		logic [11:0]  target; // Low 12 bits of jump target
	} call_fmt_t;

	// One instruction word, five layouts
	typedef union packed {
		reg_fmt_t     rtype;
		shift_fmt_t   stype;
		half_fmt_t    htype;
		branch_fmt_t  btype;
		call_fmt_t    ctype;
	} instr_u;

endpackage

`default_nettype wire

// File: common/idex_if.sv
// Decoded instruction bundle
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defs.svh"

interface idex_if;
	logic                        valid;
	cpu_pkg::alu_op_e            alu_op;
	logic                        alu_src;       // 1 selects shift amount over rt
	logic [3:0]                  shift;
	logic                        load_half;
	logic                        half_spec;     // 0 LHB, 1 LLB
	logic [7:0]                  load_half_imm;
	logic                        branch;
	logic                        call;
	logic                        ret;
	cpu_pkg::branch_cond_e       branch_cond;
	logic signed [8:0]           branch_offset;
	logic [11:0]                 call_target;
	logic                        reg_write;
	logic [`CPU_REG_W-1:0]       reg_rd;        // Writeback destination
	logic [`CPU_DATA_W-1:0]      rd_data_1;
	logic [`CPU_DATA_W-1:0]      rd_data_2;
	logic [`CPU_DATA_W-1:0]      pc;

	modport producer(output valid, alu_op, alu_src, shift, load_half, half_spec,
		load_half_imm, branch, call, ret, branch_cond, branch_offset, call_target,
		reg_write, reg_rd, rd_data_1, rd_data_2, pc);

	modport consumer(input valid, alu_op, alu_src, shift, load_half, half_spec,
		load_half_imm, branch, call, ret, branch_cond, branch_offset, call_target,
		reg_write, reg_rd, rd_data_1, rd_data_2, pc);
endinterface

`default_nettype wire

// File: cpu_core.f
+incdir+common
common/cpu_pkg.sv
common/idex_if.sv
decode/register_file.sv
decode/instr_decoder.sv
rtl/idex_reg.sv
rtl/execute_stage.sv
rtl/cpu_core.sv
tb/cpu_core_tb.sv

// File: decode/instr_decoder.sv
// Instruction decode stage
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defs.svh"

module instr_decoder (
	input  wire logic                    clk,
	input  wire logic                    reset,
	input  wire logic                    instr_valid,
	input  wire cpu_pkg::instr_u         instr,
	input  wire logic [`CPU_DATA_W-1:0]  instr_pc,
	input  wire logic                    wr_en,
	input  wire logic [`CPU_REG_W-1:0]   wr_reg,
	input  wire logic [`CPU_DATA_W-1:0]  wr_data,
	idex_if.producer                     stage
);

	logic [`CPU_REG_W-1:0]   rd_reg_1;
	logic [`CPU_REG_W-1:0]   rd_reg_2;
	logic [`CPU_DATA_W-1:0]  rd_data_1;
	logic [`CPU_DATA_W-1:0]  rd_data_2;
	logic [`CPU_REG_W-1:0]   rd_dest;
	logic                    wr_cand;   // Opcode writes a register
	logic [3:0]              op_raw;

	assign op_raw = instr.rtype.opcode;

	register_file u_regs (
		.clk       (clk),
		.reset     (reset),
		.rd_reg_1  (rd_reg_1),
		.rd_reg_2  (rd_reg_2),
		.wr_en     (wr_en),
		.wr_reg    (wr_reg),
		.wr_data   (wr_data),
		.rd_data_1 (rd_data_1),
		.rd_data_2 (rd_data_2)
	);

	always_comb begin
		rd_reg_1             = instr.rtype.rs;
		rd_reg_2             = instr.rtype.rt;
		rd_dest              = instr.rtype.rd;
		wr_cand              = 1'b0;
		stage.alu_op         = cpu_pkg::ALU_ADD;
		stage.alu_src        = 1'b0;
		stage.shift          = instr.stype.shamt;
		stage.load_half      = 1'b0;
		stage.half_spec      = 1'b0;
		stage.load_half_imm  = instr.htype.imm;
		stage.branch         = 1'b0;
		stage.call           = 1'b0;
		stage.ret            = 1'b0;
		stage.branch_cond    = instr.btype.cond;
		stage.branch_offset  = instr.btype.offset;
		stage.call_target    = instr.ctype.target;
		case (instr.rtype.opcode)
			cpu_pkg::OP_ADD, cpu_pkg::OP_SUB, cpu_pkg::OP_AND, cpu_pkg::OP_NOR: begin
				stage.alu_op = cpu_pkg::alu_op_e'(op_raw[2:0]);
				wr_cand      = 1'b1;
			end
			cpu_pkg::OP_SLL, cpu_pkg::OP_SRL, cpu_pkg::OP_SRA: begin
				stage.alu_op  = cpu_pkg::alu_op_e'(op_raw[2:0]);
				stage.alu_src = 1'b1; // Shift amount as operand 2
				wr_cand       = 1'b1;
			end
			cpu_pkg::OP_LHB: begin
				rd_reg_1        = instr.htype.rd; // Low byte kept from old rd
				stage.load_half = 1'b1;
				wr_cand         = 1'b1;
			end
			cpu_pkg::OP_LLB: begin
				stage.load_half = 1'b1;
				stage.half_spec = 1'b1;
				wr_cand         = 1'b1;
			end
			cpu_pkg::OP_B: stage.branch = 1'b1;
			cpu_pkg::OP_CALL: begin
				stage.call = 1'b1;
				rd_dest    = `CPU_REG_W'(`CPU_LINK_REG); // Return address to link reg
				wr_cand    = 1'b1;
			end
			cpu_pkg::OP_RET: begin
				stage.ret = 1'b1;
				rd_reg_1  = `CPU_REG_W'(`CPU_LINK_REG);
			end
			default: ; // Opcodes 12 to 15 do nothing
		endcase
		stage.valid     = instr_valid;
		stage.reg_write = instr_valid && wr_cand && (rd_dest != '0); // R0 stays zero
		stage.reg_rd    = rd_dest;
		stage.rd_data_1 = rd_data_1;
		stage.rd_data_2 = rd_data_2;
		stage.pc        = instr_pc;
	end

endmodule

`default_nettype wire

// File: decode/register_file.sv
// Sixteen entry register file
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defs.svh"

module register_file (
	input  wire logic                    clk,
	input  wire logic                    reset,
	input  wire logic [`CPU_REG_W-1:0]   rd_reg_1,
	input  wire logic [`CPU_REG_W-1:0]   rd_reg_2,
	input  wire logic                    wr_en,
	input  wire logic [`CPU_REG_W-1:0]   wr_reg,
	input  wire logic [`CPU_DATA_W-1:0]  wr_data,
	output logic      [`CPU_DATA_W-1:0]  rd_data_1,
	output logic      [`CPU_DATA_W-1:0]  rd_data_2
);

	logic [`CPU_DATA_W-1:0] regs [`CPU_NUM_REGS];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `CPU_NUM_REGS; i++) begin
				regs[i] <= '0; // All registers start at zero
			end
		end else if (wr_en) begin
			regs[wr_reg] <= wr_data;
		end
	end

	// Write-through so a dependent instruction in decode sees the new value
	assign rd_data_1 = (wr_en && (wr_reg == rd_reg_1)) ? wr_data : regs[rd_reg_1];
	assign rd_data_2 = (wr_en && (wr_reg == rd_reg_2)) ? wr_data : regs[rd_reg_2];

	// R0 is hardwired by never being a write target
	a_no_r0_write: assert property (
		@(posedge clk) disable iff (reset)
		wr_en |-> (wr_reg != '0)
	) else $error("register_file: write to R0");

endmodule

`default_nettype wire

// File: rtl/cpu_core.sv
// Processor core top level
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defs.svh"

module cpu_core (
	input  wire logic                    clk,
	input  wire logic                    reset,
	input  wire logic                    instr_valid,  // One cycle strobe per instruction
	input  wire logic [`CPU_DATA_W-1:0]  instr,
	input  wire logic [`CPU_DATA_W-1:0]  instr_pc,
	output logic                         wb_valid,
	output logic      [`CPU_REG_W-1:0]   wb_reg,
	output logic      [`CPU_DATA_W-1:0]  wb_data,
	output logic                         redirect,
	output logic      [`CPU_DATA_W-1:0]  redirect_pc
);

	logic                    wr_en;    // Execute to register file
	logic [`CPU_REG_W-1:0]   wr_reg;
	logic [`CPU_DATA_W-1:0]  wr_data;

	idex_if dec_bus ();  // Decoder output
	idex_if ex_bus ();   // Pipeline register output

	instr_decoder u_decoder (
		.clk         (clk),
		.reset       (reset),
		.instr_valid (instr_valid),
		.instr       (instr),
		.instr_pc    (instr_pc),
		.wr_en       (wr_en),
		.wr_reg      (wr_reg),
		.wr_data     (wr_data),
		.stage       (dec_bus.producer)
	);

	idex_reg u_idex (
		.clk   (clk),
		.reset (reset),
		.d     (dec_bus.consumer),
		.q     (ex_bus.producer)
	);

	execute_stage u_execute (
		.clk         (clk),
		.reset       (reset),
		.stage       (ex_bus.consumer),
		.wr_en       (wr_en),
		.wr_reg      (wr_reg),
		.wr_data     (wr_data),
		.wb_valid    (wb_valid),
		.wb_reg      (wb_reg),
		.wb_data     (wb_data),
		.redirect    (redirect),
		.redirect_pc (redirect_pc)
	);

endmodule

`default_nettype wire

// File: rtl/execute_stage.sv
// Execute stage with writeback and redirect
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defs.svh"

module execute_stage (
	input  wire logic                    clk,
	input  wire logic                    reset,
	idex_if.consumer                     stage,
	output logic                         wr_en,
	output logic      [`CPU_REG_W-1:0]   wr_reg,
	output logic      [`CPU_DATA_W-1:0]  wr_data,
	output logic                         wb_valid,
	output logic      [`CPU_REG_W-1:0]   wb_reg,
	output logic      [`CPU_DATA_W-1:0]  wb_data,
	output logic                         redirect,
	output logic      [`CPU_DATA_W-1:0]  redirect_pc
);

	logic [`CPU_DATA_W-1:0]  op_a, op_b, alu_res, result, pc_next, target;
	logic                    alu_ovf, is_alu, cond_met, take;
	logic                    flag_z, flag_n, flag_v; // Left by last ALU op

	always_comb begin
		op_a    = stage.rd_data_1;
		op_b    = stage.alu_src ? `CPU_DATA_W'(stage.shift) : stage.rd_data_2;
		alu_ovf = 1'b0;
		case (stage.alu_op)
			cpu_pkg::ALU_ADD: begin
				alu_res = op_a + op_b;
				alu_ovf = (op_a[`CPU_DATA_W-1] == op_b[`CPU_DATA_W-1]) &&
					(alu_res[`CPU_DATA_W-1] != op_a[`CPU_DATA_W-1]);
			end
			cpu_pkg::ALU_SUB: begin
				alu_res = op_a - op_b;
				alu_ovf = (op_a[`CPU_DATA_W-1] != op_b[`CPU_DATA_W-1]) &&
					(alu_res[`CPU_DATA_W-1] != op_a[`CPU_DATA_W-1]);
			end
			cpu_pkg::ALU_AND: alu_res = op_a & op_b;
			cpu_pkg::ALU_NOR: alu_res = ~(op_a | op_b);
			cpu_pkg::ALU_SLL: alu_res = op_a << op_b[3:0];
			cpu_pkg::ALU_SRL: alu_res = op_a >> op_b[3:0];
			cpu_pkg::ALU_SRA: alu_res = $signed(op_a) >>> op_b[3:0];
			default:          alu_res = '0;
		endcase
	end

	assign pc_next = stage.pc + `CPU_DATA_W'(1);

	always_comb begin
		if (stage.load_half && stage.half_spec)
			result = {{(`CPU_DATA_W-8){stage.load_half_imm[7]}}, stage.load_half_imm}; // LLB
		else if (stage.load_half)
			result = {stage.load_half_imm, stage.rd_data_1[7:0]}; // LHB
		else if (stage.call)
			result = pc_next; // Return address
		else
			result = alu_res;
	end

	// ALU ops aimed at R0 carry no reg_write and leave the flags alone
	assign is_alu = stage.valid && stage.reg_write && !stage.load_half && !stage.call;

	always_comb begin
		case (stage.branch_cond)
			cpu_pkg::BR_NEQ:  cond_met = !flag_z;
			cpu_pkg::BR_EQ:   cond_met = flag_z;
			cpu_pkg::BR_GT:   cond_met = !flag_z && !flag_n;
			cpu_pkg::BR_LT:   cond_met = flag_n;
			cpu_pkg::BR_GTE:  cond_met = flag_z || !flag_n;
			cpu_pkg::BR_LTE:  cond_met = flag_n || flag_z;
			cpu_pkg::BR_OVFL: cond_met = flag_v;
			default:          cond_met = 1'b1; // Unconditional
		endcase
		if (stage.call)
			target = {stage.pc[`CPU_DATA_W-1:12], stage.call_target};
		else if (stage.ret)
			target = stage.rd_data_1; // Link register value
		else
			target = pc_next + {{(`CPU_DATA_W-9){stage.branch_offset[8]}}, stage.branch_offset};
	end

	assign take = stage.valid && ((stage.branch && cond_met) || stage.call || stage.ret);

	// Register file write lands at the edge closing this cycle
	assign wr_en   = stage.valid && stage.reg_write;
	assign wr_reg  = stage.reg_rd;
	assign wr_data = result;

	always_ff @(posedge clk) begin
		if (reset) begin
			wb_valid <= 1'b0;
			redirect <= 1'b0;
			flag_z   <= 1'b0;
			flag_n   <= 1'b0;
			flag_v   <= 1'b0;
		end else begin
			wb_valid <= wr_en;
			redirect <= take;
			if (is_alu) begin
				flag_z <= (alu_res == '0);
				flag_n <= alu_res[`CPU_DATA_W-1];
				flag_v <= alu_ovf; // Cleared by non-arithmetic ops
			end
		end
	end

	always_ff @(posedge clk) begin
		wb_reg      <= wr_reg;
		wb_data     <= wr_data;
		redirect_pc <= target;
	end

	a_redirect_source: assert property (
		@(posedge clk) disable iff (reset)
		redirect |-> $past(stage.valid && (stage.branch || stage.call || stage.ret))
	) else $error("execute_stage: redirect without flow instruction");

endmodule

`default_nettype wire

// File: rtl/idex_reg.sv
// Decode to execute pipeline register
`timescale 1ns/1ps
`default_nettype none

module idex_reg (
	input wire logic   clk,
	input wire logic   reset,
	idex_if.consumer   d,
	idex_if.producer   q
);

	always_ff @(posedge clk) begin
		if (reset) q.valid <= 1'b0; // Only control bit cleared
		else       q.valid <= d.valid;
	end

	always_ff @(posedge clk) begin
		q.alu_op        <= d.alu_op;
		q.alu_src       <= d.alu_src;
		q.shift         <= d.shift;
		q.load_half     <= d.load_half;
		q.half_spec     <= d.half_spec;
		q.load_half_imm <= d.load_half_imm;
		q.branch        <= d.branch;
		q.call          <= d.call;
		q.ret           <= d.ret;
		q.branch_cond   <= d.branch_cond;
		q.branch_offset <= d.branch_offset;
		q.call_target   <= d.call_target;
		q.reg_write     <= d.reg_write; // Qualified by valid downstream
		q.reg_rd        <= d.reg_rd;
		q.rd_data_1     <= d.rd_data_1;
		q.rd_data_2     <= d.rd_data_2;
		q.pc            <= d.pc;
	end

	a_clear_after_reset: assert property (
		@(posedge clk) reset |=> !q.valid
	) else $error("idex_reg: valid set right after reset");

	// Decoder must never mark two flow changes in one bundle
	a_one_flow_change: assert property (
		@(posedge clk) disable iff (reset)
		q.valid |-> $onehot0({q.branch, q.call, q.ret})
	) else $error("idex_reg: multiple flow controls in one bundle");

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the core testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -j 0 \
	--top-module cpu_core_tb \
	-f cpu_core.f \
	-o cpu_core_sim

# Exit status of the run is ignored, the log decides
./obj_dir/cpu_core_sim > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "Simulation failed" "$LOG"; then
	exit 1
fi
if ! grep -q "Simulation completed successfully" "$LOG"; then
	echo "Run ended without a result line"
	exit 1
fi

// File: tb/cpu_core_tb.sv
// Core pipeline testbench
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defs.svh"

module cpu_core_tb;

	localparam int NUM_CYCLES  = 2000;
	localparam int DRAIN_LIMIT = 8;  // Pipeline depth is two

	typedef struct packed {
		logic                    busy;      // Slot held an instruction
		logic [3:0]              op;
		logic                    wb;
		logic [`CPU_REG_W-1:0]   wb_reg;
		logic [`CPU_DATA_W-1:0]  wb_data;
		logic                    redir;
		logic [`CPU_DATA_W-1:0]  redir_pc;
	} expect_t;

	logic                    clk;
	logic                    reset;
	logic                    instr_valid;
	logic [`CPU_DATA_W-1:0]  instr;
	logic [`CPU_DATA_W-1:0]  instr_pc;
	logic                    wb_valid;
	logic [`CPU_REG_W-1:0]   wb_reg;
	logic [`CPU_DATA_W-1:0]  wb_data;
	logic                    redirect;
	logic [`CPU_DATA_W-1:0]  redirect_pc;

	logic [31:0]             lfsr_state;
	logic [`CPU_DATA_W-1:0]  model_regs [`CPU_NUM_REGS];  // Architectural state
	logic                    model_z, model_n, model_v;
	expect_t                 exp_q [$];                     // One entry per cycle
	int                      issued;

	cpu_core dut (
		.clk         (clk),
		.reset       (reset),
		.instr_valid (instr_valid),
		.instr       (instr),
		.instr_pc    (instr_pc),
		.wb_valid    (wb_valid),
		.wb_reg      (wb_reg),
		.wb_data     (wb_data),
		.redirect    (redirect),
		.redirect_pc (redirect_pc)
	);

	always #4 clk = ~clk;  // 8 ns period

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h80200003;  // Taps 32, 22, 2, 1
		return s >> 1;
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			v = {v[30:0], lfsr_state[0]};  // One step per bit
		end
	endtask

	function automatic string op_name(input logic [3:0] op);
		case (op)
			4'd0: return "ADD";
			4'd1: return "SUB";
			4'd2: return "AND";
			4'd3: return "NOR";
			4'd4: return "SLL";
			4'd5: return "SRL";
			4'd6: return "SRA";
			4'd7: return "LHB";
			4'd8: return "LLB";
			4'd9: return "B";
			4'd10: return "CALL";
			4'd11: return "RET";
			default: return "NOP";
		endcase
	endfunction

	task automatic fail_now(input string what);
		$display("%s", what);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check_value(input string test, input string field,
		input logic [`CPU_DATA_W-1:0] expected, input logic [`CPU_DATA_W-1:0] actual);
		assert (actual === expected) else
			fail_now($sformatf("ERR %s %s expected %h actual %h", test, field, expected, actual));
	endtask

	task automatic compare_outputs(input expect_t e);
		string test;
		test = e.busy ? op_name(e.op) : "idle";
		check_value(test, "wb_valid", `CPU_DATA_W'(e.wb), `CPU_DATA_W'(wb_valid));
		if (e.wb) begin
			check_value(test, "wb_reg", `CPU_DATA_W'(e.wb_reg), `CPU_DATA_W'(wb_reg));
			check_value(test, "wb_data", e.wb_data, wb_data);
		end
		check_value(test, "redirect", `CPU_DATA_W'(e.redir), `CPU_DATA_W'(redirect));
		if (e.redir)
			check_value(test, "redirect_pc", e.redir_pc, redirect_pc);
	endtask

	task automatic write_reg(input logic [`CPU_REG_W-1:0] rd,
		input logic [`CPU_DATA_W-1:0] val, inout expect_t e);
		if (rd != '0) begin  // R0 never changes
			model_regs[rd] = val;
			e.wb      = 1'b1;
			e.wb_reg  = rd;
			e.wb_data = val;
		end
	endtask

	task automatic alu_result(input logic [`CPU_REG_W-1:0] rd,
		input logic [`CPU_DATA_W-1:0] res, input logic ovf, inout expect_t e);
		write_reg(rd, res, e);
		if (rd != '0) begin  // Discarded results leave flags alone
			model_z = (res == '0);
			model_n = res[`CPU_DATA_W-1];
			model_v = ovf;
		end
	endtask

	task automatic model_execute(input cpu_pkg::instr_u word,
		input logic [`CPU_DATA_W-1:0] pc, output expect_t e);
		logic [`CPU_DATA_W-1:0]  a;
		logic [`CPU_DATA_W-1:0]  b;
		logic [`CPU_DATA_W-1:0]  pc_inc;
		logic [3:0]              sh;
		logic [7:0]              imm;
		int                      wide;  // Exact signed result
		logic                    taken;
		e        = '0;
		e.busy   = 1'b1;
		e.op     = word.rtype.opcode;
		a        = model_regs[word.rtype.rs];
		b        = model_regs[word.rtype.rt];
		sh       = word.stype.shamt;
		imm      = word.htype.imm;
		pc_inc   = pc + `CPU_DATA_W'(1);
		case (word.rtype.opcode)
			cpu_pkg::OP_ADD: begin
				wide = int'($signed(a)) + int'($signed(b));
				alu_result(word.rtype.rd, a + b, wide > 32767 || wide < -32768, e);
			end
			cpu_pkg::OP_SUB: begin
				wide = int'($signed(a)) - int'($signed(b));
				alu_result(word.rtype.rd, a - b, wide > 32767 || wide < -32768, e);
			end
			cpu_pkg::OP_AND: alu_result(word.rtype.rd, a & b, 1'b0, e);
			cpu_pkg::OP_NOR: alu_result(word.rtype.rd, ~(a | b), 1'b0, e);
			cpu_pkg::OP_SLL: alu_result(word.stype.rd, a << sh, 1'b0, e);
			cpu_pkg::OP_SRL: alu_result(word.stype.rd, a >> sh, 1'b0, e);
			cpu_pkg::OP_SRA: alu_result(word.stype.rd,
				(a >> sh) | (a[15] ? ~(16'hffff >> sh) : 16'h0000), 1'b0, e);  // Sign fill
			cpu_pkg::OP_LHB: write_reg(word.htype.rd, {imm, model_regs[word.htype.rd][7:0]}, e);
			cpu_pkg::OP_LLB: write_reg(word.htype.rd, {{8{imm[7]}}, imm}, e);
			cpu_pkg::OP_B: begin
				case (word.btype.cond)
					cpu_pkg::BR_NEQ:  taken = !model_z;
					cpu_pkg::BR_EQ:   taken = model_z;
					cpu_pkg::BR_GT:   taken = !model_z && !model_n;
					cpu_pkg::BR_LT:   taken = model_n;
					cpu_pkg::BR_GTE:  taken = model_z || !model_n;
					cpu_pkg::BR_LTE:  taken = model_z || model_n;
					cpu_pkg::BR_OVFL: taken = model_v;
					default:          taken = 1'b1;
				endcase
				e.redir    = taken;
				e.redir_pc = pc_inc + {{7{word.btype.offset[8]}}, word.btype.offset};
			end
			cpu_pkg::OP_CALL: begin
				e.redir    = 1'b1;
				e.redir_pc = {pc[15:12], word.ctype.target};  // Same 4K region
				write_reg(`CPU_REG_W'(`CPU_LINK_REG), pc_inc, e);
			end
			cpu_pkg::OP_RET: begin
				e.redir    = 1'b1;
				e.redir_pc = model_regs[`CPU_LINK_REG];
			end
			default: ;  // Opcodes 12 to 15
		endcase
	endtask

	task automatic make_instr(output cpu_pkg::instr_u word);
		logic [31:0] r;
		logic [3:0]  op;
		take_bits(4, r);
		op = r[3:0];
		take_bits(12, r);
		word = {op, r[11:0]};  // Register and shift layouts
		case (op)
			4'd7, 4'd8: begin
				word.htype.opcode = cpu_pkg::opcode_e'(op);
				word.htype.rd     = r[11:8];
				word.htype.imm    = r[7:0];
			end
			4'd9: begin
				word.btype.opcode = cpu_pkg::OP_B;
				word.btype.cond   = cpu_pkg::branch_cond_e'(r[11:9]);
				word.btype.offset = r[8:0];
			end
			4'd10: begin
				word.ctype.opcode = cpu_pkg::OP_CALL;
				word.ctype.target = r[11:0];
			end
			default: ;
		endcase
	endtask

	initial begin
		cpu_pkg::instr_u  word;
		expect_t          e;
		expect_t          idle;
		logic [31:0]      r;
		int               drained;
		clk         = 1'b0;
		reset       = 1'b1;
		instr_valid = 1'b0;
		instr       = '0;
		instr_pc    = '0;
		lfsr_state  = 32'hfa9e321b;
		issued      = 0;
		for (int i = 0; i < `CPU_NUM_REGS; i++)
			model_regs[i] = '0;
		model_z = 1'b0;
		model_n = 1'b0;
		model_v = 1'b0;
		idle    = '0;

		@(posedge clk);
		@(negedge clk);
		compare_outputs(idle);  // Quiet while in reset
		@(posedge clk);
		#1 reset = 1'b0;
		@(negedge clk);
		compare_outputs(idle);
		exp_q.push_back(idle);  // Two cycles already in flight
		exp_q.push_back(idle);

		for (int cyc = 0; cyc < NUM_CYCLES; cyc++) begin
			@(posedge clk);
			#1;
			take_bits(7, r);
			if (r[6:0] < 7'd90) begin  // About 70 percent strobes
				make_instr(word);
				take_bits(16, r);
				instr_valid = 1'b1;
				instr       = word;
				instr_pc    = r[15:0];
				model_execute(word, r[15:0], e);
				issued++;
			end else begin
				take_bits(16, r);
				instr_valid = 1'b0;
				instr       = r[15:0];  // Junk word must be ignored
				e           = idle;
			end
			exp_q.push_back(e);
			@(negedge clk);
			compare_outputs(exp_q.pop_front());
		end

		drained = 0;
		while (exp_q.size() > 0 && drained < DRAIN_LIMIT) begin
			@(posedge clk);
			#1 instr_valid = 1'b0;
			@(negedge clk);
			compare_outputs(exp_q.pop_front());
			drained++;
		end

		if (exp_q.size() != 0 || issued == 0) begin
			fail_now("Expected results never drained or no instruction was issued");
		end else begin
			$display("Issued %0d instructions", issued);
			$display("Simulation completed successfully");
			$finish;
		end
	end

endmodule

`default_nettype wire
